// ==== ad7980_adc_model.sv ====
`timescale 1ns/1ps

module ad7980_adc_model
(
    input  logic                    cnv_i,
    input  logic                    sclk_i,
    input  ad7980_pkg::adc_sample_t value_i,
    output logic                    sdo_o,
    output int                      cnv_count_o
);
    import ad7980_pkg::*;

    localparam int SAMPLE_BITS = $bits(adc_sample_t);

    adc_sample_t shift_reg = '0;
    int          cnv_count = 0;

    // The conversion starts on the CNV rising edge and the result moves out on SCLK falling edges
    always @(posedge cnv_i or negedge sclk_i)
    begin
        if (cnv_i)
        begin
            shift_reg <= value_i;   // Analog input frozen at the start of conversion
            cnv_count <= cnv_count + 1;
        end
        else
        begin
            shift_reg <= {shift_reg[SAMPLE_BITS-2:0], 1'b0};
        end
    end

    // SDO is quiet during conversion and shows the MSB as soon as CNV drops
    assign sdo_o       = cnv_i ? 1'b0 : shift_reg[SAMPLE_BITS-1];
    assign cnv_count_o = cnv_count;

endmodule

// ==== ad7980_apb_regs.sv ====
`timescale 1ns/1ps

module ad7980_apb_regs
(
    input  logic                    fpga_clk_i,
    input  logic                    reset_i,
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  ad7980_pkg::apb_addr_t   paddr_i,
    input  ad7980_pkg::apb_data_t   pwdata_i,
    output ad7980_pkg::apb_data_t   prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o,
    output logic                    enable_o,
    output logic                    start_o,
    input  logic                    busy_i,
    input  logic                    sample_valid_i,
    input  ad7980_pkg::adc_sample_t fifo_head_i,
    input  logic [3:0]              fifo_level_i,
    input  logic                    fifo_ovf_i,
    output logic                    fifo_pop_o,
    output logic                    ovf_clear_o
);
    import ad7980_pkg::*;

    apb_data_t conv_count;
    logic      wr_acc;
    logic      rd_acc;
    logic      addr_ok;
    logic      fifo_nonempty;

    assign wr_acc        = psel_i && penable_i && pwrite_i;
    assign rd_acc        = psel_i && penable_i && !pwrite_i;
    assign addr_ok       = paddr_i inside {REG_CTRL, REG_STATUS, REG_DATA, REG_COUNT};
    assign fifo_nonempty = (fifo_level_i != 4'd0);

    assign pready_o  = 1'b1;   // No wait states
    assign pslverr_o = psel_i && penable_i && !addr_ok;

    always_ff @(posedge fpga_clk_i)
    begin
        if (reset_i)
        begin
            enable_o   <= 1'b0;
            start_o    <= 1'b0;
            conv_count <= '0;
        end
        else
        begin
            // Start is a single-cycle request and never stays set
            start_o <= wr_acc && (paddr_i == REG_CTRL) && pwdata_i[CTRL_START_BIT];
            if (wr_acc && (paddr_i == REG_CTRL))
            begin
                enable_o <= pwdata_i[CTRL_EN_BIT];
            end
            if (sample_valid_i)
            begin
                conv_count <= conv_count + 1'b1;   // Counts dropped samples too
            end
        end
    end

    assign ovf_clear_o = wr_acc && (paddr_i == REG_STATUS) && pwdata_i[STAT_OVF_BIT];
    assign fifo_pop_o  = rd_acc && (paddr_i == REG_DATA) && fifo_nonempty;

    always_comb
    begin
        prdata_o = '0;
        if (rd_acc)
        begin
            case (paddr_i)
                REG_CTRL:
                begin
                    prdata_o[CTRL_EN_BIT] = enable_o;
                end
                REG_STATUS:
                begin
                    prdata_o[STAT_BUSY_BIT]       = busy_i;
                    prdata_o[STAT_LEVEL_LSB +: 4] = fifo_level_i;
                    prdata_o[STAT_OVF_BIT]        = fifo_ovf_i;
                end
                REG_DATA:
                begin
                    if (fifo_nonempty)
                    begin
                        prdata_o[$bits(adc_sample_t)-1:0] = fifo_head_i;
                    end
                end
                REG_COUNT:
                begin
                    prdata_o = conv_count;
                end
                default:
                begin
                    prdata_o = '0;
                end
            endcase
        end
    end

    // A pop without a concurrent sample takes exactly one word out of the FIFO
    a_pop_drains: assert property (@(posedge fpga_clk_i) disable iff (reset_i)
        fifo_pop_o && !sample_valid_i |-> fifo_nonempty ##1
        fifo_level_i == $past(fifo_level_i) - 4'd1);

endmodule

// ==== ad7980_dev_if.sv ====
`timescale 1ns/1ps

module ad7980_dev_if
#(
    parameter int CYCLE_CLKS = 100,
    parameter int CNV_CLKS   = 67,
    parameter int SCLK_DIV   = 2
)
(
    input  logic                    fpga_clk_i,
    input  logic                    reset_i,
    input  logic                    enable_i,
    input  logic                    start_i,
    output logic                    busy_o,
    output logic                    sample_valid_o,
    output ad7980_pkg::adc_sample_t sample_o,
    input  logic                    adc_sdo_i,
    output logic                    adc_cnv_o,
    output logic                    adc_sclk_o
);
    import ad7980_pkg::*;

    localparam int SAMPLE_BITS = $bits(adc_sample_t);
    localparam int CYC_W       = $clog2(CYCLE_CLKS + 1);
    localparam int CNV_W       = $clog2(CNV_CLKS + 1);
    localparam int DIV_W       = $clog2(SCLK_DIV + 1);
    localparam int BIT_W       = $clog2(SAMPLE_BITS + 1);

    typedef enum logic [1:0] {IDLE, CONVERT, READ, DONE} state_t;

    state_t           state;
    logic [CYC_W-1:0] cycle_cnt;
    logic [CNV_W-1:0] cnv_cnt;
    logic [DIV_W-1:0] div_cnt;
    logic [BIT_W-1:0] bit_cnt;
    logic             sclk;
    logic             start_pend;
    logic             launch;
    logic             half_done;
    adc_sample_t      shift_reg;

    // A new cycle may begin only once the previous one's period has run out
    assign launch    = (state == IDLE) && (cycle_cnt == '0) &&
                       (enable_i || start_pend || start_i);
    assign half_done = (div_cnt == '0);

    always_ff @(posedge fpga_clk_i)
    begin
        if (reset_i)
        begin
            state      <= IDLE;
            cycle_cnt  <= '0;
            cnv_cnt    <= '0;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            sclk       <= 1'b0;
            start_pend <= 1'b0;
        end
        else
        begin
            if (launch)
            begin
                cycle_cnt <= CYC_W'(CYCLE_CLKS - 1);
            end
            else if (cycle_cnt != '0)
            begin
                cycle_cnt <= cycle_cnt - 1'b1;
            end

            // Remember a one-shot request that lands while a conversion runs
            if (launch)
            begin
                start_pend <= 1'b0;
            end
            else if (start_i)
            begin
                start_pend <= 1'b1;
            end

            case (state)
                IDLE:
                begin
                    if (launch)
                    begin
                        state   <= CONVERT;
                        cnv_cnt <= CNV_W'(CNV_CLKS - 1);
                    end
                end
                CONVERT:
                begin
                    if (cnv_cnt == '0)
                    begin
                        state   <= READ;
                        div_cnt <= DIV_W'(SCLK_DIV - 1);
                        bit_cnt <= '0;
                    end
                    else
                    begin
                        cnv_cnt <= cnv_cnt - 1'b1;
                    end
                end
                READ:
                begin
                    if (half_done)
                    begin
                        div_cnt <= DIV_W'(SCLK_DIV - 1);
                        sclk    <= ~sclk;
                        if (!sclk)
                        begin
                            bit_cnt <= bit_cnt + 1'b1;   // Rising edge
                        end
                        else if (bit_cnt == BIT_W'(SAMPLE_BITS))
                        begin
                            state <= DONE;   // Last falling edge leaves SCLK low
                        end
                    end
                    else
                    begin
                        div_cnt <= div_cnt - 1'b1;
                    end
                end
                DONE:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // SDO is stable here since the model only moves it on falling edges
    always_ff @(posedge fpga_clk_i)
    begin
        if (state == READ && half_done && !sclk)
        begin
            shift_reg <= {shift_reg[SAMPLE_BITS-2:0], adc_sdo_i};
        end
    end

    assign sample_o       = shift_reg;
    assign sample_valid_o = (state == DONE);
    assign busy_o         = (state != IDLE);
    assign adc_cnv_o      = (state == CONVERT);
    assign adc_sclk_o     = sclk;

    a_sclk_quiet_in_cnv: assert property (@(posedge fpga_clk_i) disable iff (reset_i)
        !(adc_sclk_o && adc_cnv_o));

    a_valid_single: assert property (@(posedge fpga_clk_i) disable iff (reset_i)
        sample_valid_o |=> !sample_valid_o);

endmodule

// ==== ad7980_pkg.sv ====
package ad7980_pkg;

    // One conversion result, straight binary from the converter
    typedef logic [15:0] adc_sample_t;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Register map, one 32-bit word per register
    localparam apb_addr_t REG_CTRL   = 8'h00;
    localparam apb_addr_t REG_STATUS = 8'h04;
    localparam apb_addr_t REG_DATA   = 8'h08;
    localparam apb_addr_t REG_COUNT  = 8'h0C;

    // CTRL bits
    localparam int CTRL_EN_BIT    = 0;   // Continuous conversion enable
    localparam int CTRL_START_BIT = 1;   // One-shot request, reads back 0

    // STATUS bits
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_LEVEL_LSB = 4;   // Four-bit FIFO level field
    localparam int STAT_OVF_BIT   = 8;   // Sticky, write 1 to clear

endpackage

// ==== ad7980_sample_fifo.sv ====
`timescale 1ns/1ps

module ad7980_sample_fifo
#(
    parameter int FIFO_DEPTH = 8   // Power of two from 2 to 8
)
(
    input  logic                    fpga_clk_i,
    input  logic                    reset_i,
    input  logic                    wr_en_i,
    input  ad7980_pkg::adc_sample_t wr_data_i,
    input  logic                    rd_en_i,
    output ad7980_pkg::adc_sample_t rd_data_o,
    output logic [3:0]              level_o,
    output logic                    overflow_o,
    input  logic                    ovf_clear_i
);
    import ad7980_pkg::*;

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    adc_sample_t     mem [FIFO_DEPTH];
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;
    logic [ADDR_W:0] count;
    logic            full;
    logic            empty;
    logic            do_wr;
    logic            do_rd;

    // Extra pointer bit tells full from empty
    assign count = wr_ptr - rd_ptr;
    assign full  = (count == (ADDR_W+1)'(FIFO_DEPTH));
    assign empty = (wr_ptr == rd_ptr);
    assign do_wr = wr_en_i && !full;   // The converter cannot stall, so a full FIFO drops
    assign do_rd = rd_en_i && !empty;

    always_ff @(posedge fpga_clk_i)
    begin
        if (reset_i)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            overflow_o <= 1'b0;
        end
        else
        begin
            if (do_wr)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_en_i && full)
            begin
                overflow_o <= 1'b1;   // A new drop wins over a clear
            end
            else if (ovf_clear_i)
            begin
                overflow_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge fpga_clk_i)
    begin
        if (do_wr)
        begin
            mem[wr_ptr[ADDR_W-1:0]] <= wr_data_i;
        end
    end

    assign rd_data_o = mem[rd_ptr[ADDR_W-1:0]];
    assign level_o   = 4'(count);

    a_level_bound: assert property (@(posedge fpga_clk_i) disable iff (reset_i)
        level_o <= 4'(FIFO_DEPTH));

endmodule

// ==== ad7980_top.sv ====
`timescale 1ns/1ps

module ad7980_top
#(
    parameter int CYCLE_CLKS = 100,
    parameter int CNV_CLKS   = 67,
    parameter int SCLK_DIV   = 2,
    parameter int FIFO_DEPTH = 8
)
(
    input  logic                  fpga_clk_i,
    input  logic                  reset_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  ad7980_pkg::apb_addr_t paddr_i,
    input  ad7980_pkg::apb_data_t pwdata_i,
    output ad7980_pkg::apb_data_t prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,
    input  logic                  adc_sdo_i,
    output logic                  adc_cnv_o,
    output logic                  adc_sclk_o
);
    import ad7980_pkg::*;

    logic        enable;
    logic        start;
    logic        busy;
    logic        sample_valid;
    adc_sample_t sample;
    adc_sample_t fifo_head;
    logic [3:0]  fifo_level;
    logic        fifo_ovf;
    logic        fifo_pop;
    logic        ovf_clear;

    ad7980_dev_if #(
        .CYCLE_CLKS (CYCLE_CLKS),
        .CNV_CLKS   (CNV_CLKS),
        .SCLK_DIV   (SCLK_DIV)
    ) dev_if0 (
        .fpga_clk_i     (fpga_clk_i),
        .reset_i        (reset_i),
        .enable_i       (enable),
        .start_i        (start),
        .busy_o         (busy),
        .sample_valid_o (sample_valid),
        .sample_o       (sample),
        .adc_sdo_i      (adc_sdo_i),
        .adc_cnv_o      (adc_cnv_o),
        .adc_sclk_o     (adc_sclk_o)
    );

    ad7980_sample_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo0 (
        .fpga_clk_i  (fpga_clk_i),
        .reset_i     (reset_i),
        .wr_en_i     (sample_valid),
        .wr_data_i   (sample),
        .rd_en_i     (fifo_pop),
        .rd_data_o   (fifo_head),
        .level_o     (fifo_level),
        .overflow_o  (fifo_ovf),
        .ovf_clear_i (ovf_clear)
    );

    ad7980_apb_regs regs0 (
        .fpga_clk_i     (fpga_clk_i),
        .reset_i        (reset_i),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .paddr_i        (paddr_i),
        .pwdata_i       (pwdata_i),
        .prdata_o       (prdata_o),
        .pready_o       (pready_o),
        .pslverr_o      (pslverr_o),
        .enable_o       (enable),
        .start_o        (start),
        .busy_i         (busy),
        .sample_valid_i (sample_valid),
        .fifo_head_i    (fifo_head),
        .fifo_level_i   (fifo_level),
        .fifo_ovf_i     (fifo_ovf),
        .fifo_pop_o     (fifo_pop),
        .ovf_clear_o    (ovf_clear)
    );

endmodule

// ==== tb_ad7980_top.sv ====
`timescale 1ns/1ps

module tb_ad7980_top;
    import ad7980_pkg::*;

    localparam int        CYCLE_CLKS  = 100;
    localparam int        CNV_CLKS    = 67;
    localparam int        SCLK_DIV    = 2;
    localparam int        FIFO_DEPTH  = 8;
    localparam int        CLK_PERIOD  = 100;
    localparam longint    WATCHDOG_NS = 64'd40 * CYCLE_CLKS * CLK_PERIOD * 3;
    localparam apb_addr_t BAD_ADDR    = 8'h10;

    logic        fpga_clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    apb_data_t   pwdata;
    apb_data_t   prdata;
    logic        pready;
    logic        pslverr;
    logic        adc_sdo;
    logic        adc_cnv;
    logic        adc_sclk;
    adc_sample_t model_value;
    adc_sample_t sample_offset;
    int          cnv_count;

    string       chk_name_q[$];
    apb_data_t   chk_exp_q[$];
    apb_data_t   chk_act_q[$];
    int          checks_queued = 0;
    int          checks_done   = 0;
    int          error_count   = 0;
    int          tests_failed  = 0;

    ad7980_top #(
        .CYCLE_CLKS (CYCLE_CLKS),
        .CNV_CLKS   (CNV_CLKS),
        .SCLK_DIV   (SCLK_DIV),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut0 (
        .fpga_clk_i (fpga_clk),
        .reset_i    (reset),
        .psel_i     (psel),
        .penable_i  (penable),
        .pwrite_i   (pwrite),
        .paddr_i    (paddr),
        .pwdata_i   (pwdata),
        .prdata_o   (prdata),
        .pready_o   (pready),
        .pslverr_o  (pslverr),
        .adc_sdo_i  (adc_sdo),
        .adc_cnv_o  (adc_cnv),
        .adc_sclk_o (adc_sclk)
    );

    ad7980_adc_model adc0 (
        .cnv_i       (adc_cnv),
        .sclk_i      (adc_sclk),
        .value_i     (model_value),
        .sdo_o       (adc_sdo),
        .cnv_count_o (cnv_count)
    );

    // Expected result of the n-th conversion since reset
    function automatic adc_sample_t sample_for(input int n);
        return adc_sample_t'(n * 16'h9e37) ^ sample_offset;
    endfunction

    always @(cnv_count or sample_offset)
    begin
        model_value = sample_for(cnv_count);
    end

    initial
    begin
        fpga_clk = 1'b0;
        forever #(CLK_PERIOD / 2) fpga_clk = ~fpga_clk;
    end

    task automatic expect_value(input string name, input apb_data_t exp_v,
                                input apb_data_t act_v);
        chk_name_q.push_back(name);
        chk_exp_q.push_back(exp_v);
        chk_act_q.push_back(act_v);
        checks_queued++;
    endtask

    task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata);
        logic addr_valid;
        addr_valid = addr inside {REG_CTRL, REG_STATUS, REG_DATA, REG_COUNT};
        @(negedge fpga_clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge fpga_clk);
        penable = 1'b1;
        #(CLK_PERIOD / 4);   // A quarter period before the rising edge that ends the access
        rdata = prdata;
        expect_value("PSLVERR", apb_data_t'(!addr_valid), apb_data_t'(pslverr));
        expect_value("PREADY", 32'h1, apb_data_t'(pready));
        @(negedge fpga_clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        apb_data_t unused;
        apb_access(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
        apb_access(1'b0, addr, '0, data);
    endtask

    task automatic read_expect(input string name, input apb_addr_t addr, input apb_data_t exp_v);
        apb_data_t data;
        apb_read(addr, data);
        expect_value(name, exp_v, data);
    endtask

    task automatic wait_level(input int lvl);
        apb_data_t st;
        do
        begin
            apb_read(REG_STATUS, st);
        end
        while (st[STAT_LEVEL_LSB +: 4] < lvl);
    endtask

    task automatic wait_idle();
        apb_data_t st;
        do
        begin
            apb_read(REG_STATUS, st);
        end
        while (st[STAT_BUSY_BIT]);
    endtask

    task automatic wait_count(input apb_data_t target);
        apb_data_t cnt;
        do
        begin
            apb_read(REG_COUNT, cnt);
        end
        while (cnt < target);
    endtask

    task automatic report_test(input int num, input string title, input int errs_before);
        wait (checks_done == checks_queued);
        if (error_count == errs_before)
        begin
            $display("Test %0d %s: ok", num, title);
        end
        else
        begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", num, title, error_count - errs_before);
        end
    endtask

    // Compares every queued read against its expected value
    initial
    begin
        string     name;
        apb_data_t exp_v;
        apb_data_t act_v;
        forever
        begin
            wait (checks_queued > checks_done);
            name  = chk_name_q.pop_front();
            exp_v = chk_exp_q.pop_front();
            act_v = chk_act_q.pop_front();
            if (act_v !== exp_v)
            begin
                error_count++;
                $display("MISMATCH at %0d ns: %s expected 0x%08h, actual 0x%08h",
                         $time, name, exp_v, act_v);
            end
            checks_done++;
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("The run timed out after %0d ns before all tests finished", WATCHDOG_NS);
        $display("=== FAIL ===");
        $finish;
    end

    initial
    begin
        apb_data_t base;
        apb_data_t cnt;
        apb_data_t st;
        int        level;
        int        errs;

        void'($urandom(32'h7370f82b));
        sample_offset = adc_sample_t'($urandom);
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (2) @(negedge fpga_clk);
        reset = 1'b0;

        errs = error_count;
        read_expect("CTRL", REG_CTRL, 32'h0);
        read_expect("STATUS", REG_STATUS, 32'h0);
        read_expect("COUNT", REG_COUNT, 32'h0);
        read_expect("DATA", REG_DATA, 32'h0);   // Empty FIFO reads as zero
        report_test(1, "reset values", errs);

        errs = error_count;
        apb_write(REG_CTRL, 32'h1 << CTRL_START_BIT);
        read_expect("CTRL", REG_CTRL, 32'h0);
        wait_level(1);
        read_expect("STATUS", REG_STATUS, 32'h1 << STAT_LEVEL_LSB);
        read_expect("DATA", REG_DATA, apb_data_t'(sample_for(0)));
        read_expect("COUNT", REG_COUNT, 32'd1);
        read_expect("STATUS", REG_STATUS, 32'h0);
        report_test(2, "one-shot conversion", errs);

        errs = error_count;
        apb_read(REG_COUNT, base);
        apb_write(REG_CTRL, 32'h1 << CTRL_EN_BIT);
        wait_level(4);
        apb_write(REG_CTRL, 32'h0);
        wait_idle();
        apb_read(REG_STATUS, st);
        level = st[STAT_LEVEL_LSB +: 4];
        apb_read(REG_COUNT, cnt);
        expect_value("COUNT increase", apb_data_t'(level), cnt - base);
        for (int i = 0; i < level; i++)
        begin
            read_expect("DATA", REG_DATA, apb_data_t'(sample_for(base + i)));
        end
        read_expect("STATUS", REG_STATUS, 32'h0);
        report_test(3, "continuous conversion", errs);

        errs = error_count;
        apb_read(REG_COUNT, base);
        expect_value("COUNT", apb_data_t'(cnv_count), base);
        apb_write(REG_CTRL, 32'h1 << CTRL_EN_BIT);
        wait_count(base + FIFO_DEPTH + 2);   // Two more than the FIFO holds
        apb_write(REG_CTRL, 32'h0);
        wait_idle();
        read_expect("STATUS", REG_STATUS,
                    (32'h1 << STAT_OVF_BIT) | (apb_data_t'(FIFO_DEPTH) << STAT_LEVEL_LSB));
        for (int i = 0; i < FIFO_DEPTH; i++)
        begin
            read_expect("DATA", REG_DATA, apb_data_t'(sample_for(base + i)));
        end
        read_expect("COUNT", REG_COUNT, apb_data_t'(cnv_count));
        apb_write(REG_STATUS, 32'h1 << STAT_OVF_BIT);
        read_expect("STATUS", REG_STATUS, 32'h0);
        report_test(4, "FIFO overflow", errs);

        errs = error_count;
        apb_read(REG_COUNT, cnt);
        read_expect("PRDATA", BAD_ADDR, 32'h0);
        apb_write(BAD_ADDR, 32'hffff_ffff);
        read_expect("CTRL", REG_CTRL, 32'h0);
        read_expect("STATUS", REG_STATUS, 32'h0);
        read_expect("COUNT", REG_COUNT, cnt);
        report_test(5, "bus errors", errs);

        $display("Tests: 5, failed: %0d, checks: %0d, errors: %0d",
                 tests_failed, checks_done, error_count);
        if (error_count == 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
ad7980_pkg.sv
ad7980_dev_if.sv
ad7980_sample_fifo.sv
ad7980_apb_regs.sv
ad7980_top.sv
ad7980_adc_model.sv
tb_ad7980_top.sv
